// ==== rtl/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    localparam int unsigned xlen = 32;

    typedef logic [4:0]        reg_idx_t;
    typedef logic [xlen-1:0]   word_t;

    localparam word_t reset_pc = 32'h0000_0000;

    // Major opcode field of the base instruction set
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_op     = 7'b0110011;

    // Internal operation codes as the dispatcher expects them
    typedef enum logic [6:0] {
        op_invalid = 7'd0,
        op_lui, op_auipc, op_jal, op_jalr,                  // 1 .. 4
        op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,   // 5 .. 10
        op_lb, op_lh, op_lw, op_lbu, op_lhu,                // 11 .. 15
        op_sb, op_sh, op_sw,                                // 16 .. 18
        op_addi, op_slti, op_sltiu, op_xori, op_ori, op_andi,
        op_slli, op_srli, op_srai,                          // 19 .. 27
        op_add, op_sub, op_sll, op_slt, op_sltu,
        op_xorr, op_srl, op_sra, op_orr, op_andr            // 28 .. 37
    } op_t;

    // One instruction word seen through each base format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            reg_idx_t   rs2;
            reg_idx_t   rs1;
            logic [2:0] funct3;
            reg_idx_t   rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm_11_0;
            reg_idx_t    rs1;
            logic [2:0]  funct3;
            reg_idx_t    rd;
            logic [6:0]  opcode;
        } i_fmt;
        struct packed {
            logic [6:0] imm_11_5;
            reg_idx_t   rs2;
            reg_idx_t   rs1;
            logic [2:0] funct3;
            logic [4:0] imm_4_0;
            logic [6:0] opcode;
        } s_fmt;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            reg_idx_t   rs2;
            reg_idx_t   rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } b_fmt;
        struct packed {
            logic [19:0] imm_31_12;
            reg_idx_t    rd;
            logic [6:0]  opcode;
        } u_fmt;
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            reg_idx_t   rd;
            logic [6:0] opcode;
        } j_fmt;
    } insn_u;

    typedef struct packed {
        op_t      op;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        word_t    imm;
    } decoded_t;

    typedef struct packed {
        word_t    pc;
        op_t      op;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        word_t    imm;
        logic     predict_taken;
    } issue_pkt_t;

    typedef enum logic [1:0] {
        st_idle,
        st_wait_icache,
        st_wait_jalr,
        st_issuing
    } fetch_state_t;

endpackage

`default_nettype wire

// ==== rtl/rv32i_decoder.sv ====
`default_nettype none

module rv32i_decoder import fetch_pkg::*; (
    input  insn_u    insn,
    output decoded_t dec
);

    logic [2:0] funct3;
    logic [6:0] funct7;

    assign funct3 = insn.r_fmt.funct3;
    assign funct7 = insn.r_fmt.funct7;

    always_comb begin
        dec = '0;
        case (insn.r_fmt.opcode)
            opc_lui, opc_auipc: begin
                dec.op  = (insn.u_fmt.opcode == opc_lui) ? op_lui : op_auipc;
                dec.rd  = insn.u_fmt.rd;
                dec.imm = {insn.u_fmt.imm_31_12, 12'b0};
            end
            opc_jal: begin
                dec.op  = op_jal;
                dec.rd  = insn.j_fmt.rd;
                dec.imm = {{11{insn.j_fmt.imm_20}}, insn.j_fmt.imm_20, insn.j_fmt.imm_19_12,
                           insn.j_fmt.imm_11, insn.j_fmt.imm_10_1, 1'b0};
            end
            opc_jalr: begin
                if (funct3 == 3'b000) dec.op = op_jalr;
                dec.rs1 = insn.i_fmt.rs1;
                dec.rd  = insn.i_fmt.rd;
                dec.imm = {{20{insn.i_fmt.imm_11_0[11]}}, insn.i_fmt.imm_11_0};
            end
            opc_branch: begin
                case (funct3)
                    3'b000:  dec.op = op_beq;
                    3'b001:  dec.op = op_bne;
                    3'b100:  dec.op = op_blt;
                    3'b101:  dec.op = op_bge;
                    3'b110:  dec.op = op_bltu;
                    3'b111:  dec.op = op_bgeu;
                    default: dec.op = op_invalid;
                endcase
                dec.rs1 = insn.b_fmt.rs1;
                dec.rs2 = insn.b_fmt.rs2;
                dec.imm = {{19{insn.b_fmt.imm_12}}, insn.b_fmt.imm_12, insn.b_fmt.imm_11,
                           insn.b_fmt.imm_10_5, insn.b_fmt.imm_4_1, 1'b0};
            end
            opc_load: begin
                case (funct3)
                    3'b000:  dec.op = op_lb;
                    3'b001:  dec.op = op_lh;
                    3'b010:  dec.op = op_lw;
                    3'b100:  dec.op = op_lbu;
                    3'b101:  dec.op = op_lhu;
                    default: dec.op = op_invalid;
                endcase
                dec.rs1 = insn.i_fmt.rs1;
                dec.rd  = insn.i_fmt.rd;
                dec.imm = {{20{insn.i_fmt.imm_11_0[11]}}, insn.i_fmt.imm_11_0};
            end
            opc_store: begin
                case (funct3)
                    3'b000:  dec.op = op_sb;
                    3'b001:  dec.op = op_sh;
                    3'b010:  dec.op = op_sw;
                    default: dec.op = op_invalid;
                endcase
                dec.rs1 = insn.s_fmt.rs1;
                dec.rs2 = insn.s_fmt.rs2;
                dec.imm = {{20{insn.s_fmt.imm_11_5[6]}}, insn.s_fmt.imm_11_5, insn.s_fmt.imm_4_0};
            end
            opc_op_imm: begin
                dec.rs1 = insn.i_fmt.rs1;
                dec.rd  = insn.i_fmt.rd;
                dec.imm = {{20{insn.i_fmt.imm_11_0[11]}}, insn.i_fmt.imm_11_0};
                case (funct3)
                    3'b000: dec.op = op_addi;
                    3'b010: dec.op = op_slti;
                    3'b011: dec.op = op_sltiu;
                    3'b100: dec.op = op_xori;
                    3'b110: dec.op = op_ori;
                    3'b111: dec.op = op_andi;
                    3'b001: dec.op = (funct7 == 7'b0000000) ? op_slli : op_invalid;
                    default: begin
                        if (funct7 == 7'b0000000) dec.op = op_srli;
                        else if (funct7 == 7'b0100000) dec.op = op_srai;
                    end
                endcase
                // Shifts carry only the shift amount
                if (funct3 == 3'b001 || funct3 == 3'b101) dec.imm = {27'b0, insn.r_fmt.rs2};
            end
            opc_op: begin
                dec.rs1 = insn.r_fmt.rs1;
                dec.rs2 = insn.r_fmt.rs2;
                dec.rd  = insn.r_fmt.rd;
                if (funct7 == 7'b0000000) begin
                    case (funct3)
                        3'b000: dec.op = op_add;
                        3'b001: dec.op = op_sll;
                        3'b010: dec.op = op_slt;
                        3'b011: dec.op = op_sltu;
                        3'b100: dec.op = op_xorr;
                        3'b101: dec.op = op_srl;
                        3'b110: dec.op = op_orr;
                        default: dec.op = op_andr;
                    endcase
                end else if (funct7 == 7'b0100000) begin
                    if (funct3 == 3'b000) dec.op = op_sub;
                    else if (funct3 == 3'b101) dec.op = op_sra;
                end
            end
            default: dec = '0;
        endcase
        if (dec.op == op_invalid) dec = '0; // Unknown encodings leave nothing behind
    end

endmodule

`default_nettype wire

// ==== rtl/next_pc_unit.sv ====
`default_nettype none

module next_pc_unit import fetch_pkg::*; (
    input  word_t pc,
    input  op_t   op,
    input  word_t imm,
    input  logic  predict_taken,
    output word_t next_pc,
    output logic  wait_target
);

    word_t seq_pc;
    word_t jump_pc;

    assign seq_pc  = pc + 32'd4;
    assign jump_pc = pc + imm;   // Same adder serves jal and taken branches

    always_comb begin
        case (op)
            op_jal: begin
                next_pc = jump_pc;
            end
            op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu: begin
                next_pc = predict_taken ? jump_pc : seq_pc;
            end
            default: begin
                next_pc = seq_pc;
            end
        endcase
    end

    // Target of jalr depends on a register value, only the back end knows it
    assign wait_target = (op == op_jalr);

endmodule

`default_nettype wire

// ==== rtl/fetch_control.sv ====
`default_nettype none

module fetch_control import fetch_pkg::*; (
    input  logic       clk_in,
    input  logic       rst_in,
    input  logic       rdy_in,
    input  logic       icache_data_en,
    input  word_t      icache_data,
    input  logic       jalr_result_en,
    input  word_t      jalr_result,
    input  logic       flush_signal,
    input  word_t      correct_next_pc,
    input  logic       new_instruction_able,
    input  logic       predict_result,
    input  decoded_t   dec,
    input  word_t      next_pc,
    input  logic       wait_target,
    output insn_u      cur_insn,
    output word_t      cur_pc,
    output logic       icache_query_en,
    output word_t      icache_query_pc,
    output word_t      predict_query_pc,
    output logic       new_instruction_en,
    output issue_pkt_t new_issue
);

    fetch_state_t state;
    word_t        pc;
    logic         run;
    logic         issue_now;

    assign run       = rdy_in && !flush_signal;
    assign issue_now = (state == st_issuing) && new_instruction_able;
    assign cur_pc    = pc;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state              <= st_idle;
            pc                 <= reset_pc;
            icache_query_en    <= 1'b0;
            new_instruction_en <= 1'b0;
        end else if (!rdy_in) begin
            new_instruction_en <= 1'b0; // A pause must not stretch the issue pulse
        end else if (flush_signal) begin
            // Mispredict somewhere behind us, restart from the correct pc
            state              <= st_idle;
            pc                 <= correct_next_pc;
            icache_query_en    <= 1'b0;
            new_instruction_en <= 1'b0;
        end else begin
            new_instruction_en <= 1'b0;
            case (state)
                st_idle: begin
                    icache_query_en <= 1'b1;
                    state           <= st_wait_icache;
                end
                st_wait_icache: begin
                    if (icache_data_en) begin
                        icache_query_en <= 1'b0;
                        state           <= st_issuing;
                    end
                end
                st_issuing: begin
                    if (new_instruction_able) begin
                        new_instruction_en <= 1'b1;
                        if (wait_target) begin
                            state <= st_wait_jalr;  // pc reloads from the back end
                        end else begin
                            pc    <= next_pc;
                            state <= st_idle;
                        end
                    end
                end
                default: begin // st_wait_jalr
                    if (jalr_result_en) begin
                        pc    <= jalr_result;
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

    // Payload registers follow the same state decisions
    always_ff @(posedge clk_in) begin
        if (run) begin
            if (state == st_idle) begin
                icache_query_pc  <= pc;
                predict_query_pc <= pc;
            end
            if (state == st_wait_icache && icache_data_en) begin
                cur_insn <= icache_data;  // Word stays put under back-pressure
            end
            if (issue_now) begin
                new_issue <= '{pc: pc, op: dec.op, rs1: dec.rs1, rs2: dec.rs2, rd: dec.rd,
                               imm: dec.imm, predict_taken: predict_result};
            end
        end
    end

    // Issue is a strobe, the dispatcher counts every high cycle
    a_issue_pulse: assert property (@(posedge clk_in) disable iff (rst_in)
        new_instruction_en |=> !new_instruction_en);

    a_query_stable: assert property (@(posedge clk_in) disable iff (rst_in)
        icache_query_en && !icache_data_en |=> $stable(icache_query_pc));

    // The back end answers only while the fetcher waits for a jalr target
    a_jalr_accept: assert property (@(posedge clk_in) disable iff (rst_in)
        jalr_result_en && rdy_in && !flush_signal |-> state == st_wait_jalr);

endmodule

`default_nettype wire

// ==== rtl/instruction_fetcher.sv ====
`default_nettype none

module instruction_fetcher import fetch_pkg::*; (
    input  logic       clk_in,
    input  logic       rst_in,
    input  logic       rdy_in,
    output logic       icache_query_en,
    output word_t      icache_query_pc,
    input  logic       icache_data_en,
    input  word_t      icache_data,
    input  logic       jalr_result_en,
    input  word_t      jalr_result,
    input  logic       flush_signal,
    input  word_t      correct_next_pc,
    input  logic       new_instruction_able,
    output logic       new_instruction_en,
    output issue_pkt_t new_issue,
    output word_t      predict_query_pc,
    input  logic       predict_result
);

    insn_u    cur_insn;
    word_t    cur_pc;
    decoded_t dec;
    word_t    next_pc;
    logic     wait_target;

    fetch_control u_control (
        .clk_in               (clk_in),
        .rst_in               (rst_in),
        .rdy_in               (rdy_in),
        .icache_data_en       (icache_data_en),
        .icache_data          (icache_data),
        .jalr_result_en       (jalr_result_en),
        .jalr_result          (jalr_result),
        .flush_signal         (flush_signal),
        .correct_next_pc      (correct_next_pc),
        .new_instruction_able (new_instruction_able),
        .predict_result       (predict_result),
        .dec                  (dec),
        .next_pc              (next_pc),
        .wait_target          (wait_target),
        .cur_insn             (cur_insn),
        .cur_pc               (cur_pc),
        .icache_query_en      (icache_query_en),
        .icache_query_pc      (icache_query_pc),
        .predict_query_pc     (predict_query_pc),
        .new_instruction_en   (new_instruction_en),
        .new_issue            (new_issue)
    );

    // Decode works on the latched word while the machine sits in issuing
    rv32i_decoder u_decoder (
        .insn (cur_insn),
        .dec  (dec)
    );

    next_pc_unit u_next_pc (
        .pc            (cur_pc),
        .op            (dec.op),
        .imm           (dec.imm),
        .predict_taken (predict_result),
        .next_pc       (next_pc),
        .wait_target   (wait_target)
    );

endmodule

`default_nettype wire

// ==== verification/fetcher_ref.svh ====
`ifndef FETCHER_REF_SVH
`define FETCHER_REF_SVH

// Expected issue packet for one base word, following the RV32I encoding tables
function automatic issue_pkt_t ref_issue(input word_t w, input word_t pc, input logic taken,
                                         output word_t npc);
    issue_pkt_t p;
    logic [2:0] f3;
    logic [6:0] f7;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_j;
    p     = '0;
    f3    = w[14:12];
    f7    = w[31:25];
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
    imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    case (w[6:0])
        opc_lui, opc_auipc: begin
            p.op  = (w[6:0] == opc_lui) ? op_lui : op_auipc;
            p.rd  = w[11:7];
            p.imm = {w[31:12], 12'b0};
        end
        opc_jal: begin
            p.op  = op_jal;
            p.rd  = w[11:7];
            p.imm = imm_j;
        end
        opc_jalr: begin
            if (f3 == 3'd0) p.op = op_jalr;
            p.rs1 = w[19:15];
            p.rd  = w[11:7];
            p.imm = imm_i;
        end
        opc_branch: begin
            if (f3 != 3'd2 && f3 != 3'd3) p.op = op_t'(op_beq + ((f3 < 3'd4) ? f3 : f3 - 3'd2));
            p.rs1 = w[19:15];
            p.rs2 = w[24:20];
            p.imm = imm_b;
        end
        opc_load: begin
            if (f3 inside {3'd0, 3'd1, 3'd2}) p.op = op_t'(op_lb + f3);
            else if (f3 inside {3'd4, 3'd5}) p.op = op_t'(op_lb + f3 - 3'd1);
            p.rs1 = w[19:15];
            p.rd  = w[11:7];
            p.imm = imm_i;
        end
        opc_store: begin
            if (f3 < 3'd3) p.op = op_t'(op_sb + f3);
            p.rs1 = w[19:15];
            p.rs2 = w[24:20];
            p.imm = imm_s;
        end
        opc_op_imm: begin
            p.rs1 = w[19:15];
            p.rd  = w[11:7];
            p.imm = imm_i;
            case (f3)
                3'd0: p.op = op_addi;
                3'd2: p.op = op_slti;
                3'd3: p.op = op_sltiu;
                3'd4: p.op = op_xori;
                3'd6: p.op = op_ori;
                3'd7: p.op = op_andi;
                3'd1: if (f7 == 7'h00) p.op = op_slli;
                default: begin
                    if (f7 == 7'h00) p.op = op_srli;
                    if (f7 == 7'h20) p.op = op_srai;
                end
            endcase
            if (f3 == 3'd1 || f3 == 3'd5) p.imm = {27'b0, w[24:20]}; // shamt only
        end
        opc_op: begin
            p.rs1 = w[19:15];
            p.rs2 = w[24:20];
            p.rd  = w[11:7];
            if (f7 == 7'h00) begin
                case (f3)
                    3'd0: p.op = op_add;
                    3'd1: p.op = op_sll;
                    3'd2: p.op = op_slt;
                    3'd3: p.op = op_sltu;
                    3'd4: p.op = op_xorr;
                    3'd5: p.op = op_srl;
                    3'd6: p.op = op_orr;
                    3'd7: p.op = op_andr;
                endcase
            end else if (f7 == 7'h20 && f3 == 3'd0) begin
                p.op = op_sub;
            end else if (f7 == 7'h20 && f3 == 3'd5) begin
                p.op = op_sra;
            end
        end
        default: p.op = op_invalid;
    endcase
    if (p.op == op_invalid) p = '0;
    p.pc            = pc;
    p.predict_taken = taken;
    if (p.op == op_jal) npc = pc + p.imm;
    else if (p.op inside {op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu} && taken)
        npc = pc + p.imm;
    else
        npc = pc + 32'd4;
    return p;
endfunction

task automatic check_issue(input string name, input issue_pkt_t exp, input issue_pkt_t act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("[ERROR] %s: packet expected %h, actual %h", name, exp, act);
    end
endtask

task automatic check_pc(input string name, input word_t exp, input word_t act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("[ERROR] %s: pc expected %h, actual %h", name, exp, act);
    end
endtask

`endif

// ==== verification/fetcher_tb.sv ====
`default_nettype none

module fetcher_tb import fetch_pkg::*; ();

    logic       clk_in;
    logic       rst_in;
    logic       rdy_in;
    logic       icache_query_en;
    word_t      icache_query_pc;
    logic       icache_data_en;
    word_t      icache_data;
    logic       jalr_result_en;
    word_t      jalr_result;
    logic       flush_signal;
    word_t      correct_next_pc;
    logic       new_instruction_able;
    logic       new_instruction_en;
    issue_pkt_t new_issue;
    word_t      predict_query_pc;
    logic       predict_result;

    word_t       mem [0:1023];     // 4 KiB program space
    int unsigned errors;
    int unsigned checks;
    int unsigned issued;
    word_t       exp_pc;
    word_t       jalr_target;
    string       cur_test;
    logic        stress;
    int unsigned delay;
    logic        busy;
    logic        timed_out;

    `include "fetcher_ref.svh"

    instruction_fetcher dut0 (.*);

    initial clk_in = 1'b0;
    always #4 clk_in = ~clk_in;

    // Cache model, answers 1 to 4 cycles after the query shows up
    always @(posedge clk_in) begin
        if (rst_in) begin
            busy = 1'b0;
            icache_data_en <= 1'b0;
        end else if (icache_data_en) begin
            icache_data_en <= 1'b0;
            busy = 1'b0;
        end else if (busy && !icache_query_en) begin
            busy = 1'b0;                       // Query withdrawn by a flush
        end else if (busy) begin
            if (delay <= 1) begin
                icache_data_en <= 1'b1;
                icache_data    <= mem[icache_query_pc[11:2]];
            end else begin
                delay--;
            end
        end else if (icache_query_en) begin
            busy = 1'b1;
            delay = 1 + $urandom % 4;
        end
    end

    always @(posedge clk_in) predict_result <= predict_query_pc[2];

    // Back end returns the jalr target a few cycles after issue
    always @(posedge clk_in) begin
        if (rst_in) begin
            jalr_result_en <= 1'b0;
        end else if (jalr_result_en) begin
            jalr_result_en <= 1'b0;
        end else if (new_instruction_en && new_issue.op == op_jalr) begin
            repeat (2 + $urandom % 3) begin
                @(posedge clk_in);
                if (icache_query_en) begin
                    errors++;
                    $display("Cache was queried while the fetcher waited for a jalr target");
                end
            end
            jalr_result_en <= 1'b1;
            jalr_result    <= jalr_target;
        end
    end

    always @(posedge clk_in) begin
        if (stress) begin
            rdy_in               <= ($urandom % 4) != 0;
            new_instruction_able <= ($urandom % 3) != 0;
        end
    end

    // Follows the program through the reference and compares every issue
    always @(posedge clk_in) begin : compare
        issue_pkt_t exp;
        word_t      nxt;
        if (!rst_in) begin
            if (new_instruction_en) begin
                exp = ref_issue(mem[exp_pc[11:2]], exp_pc, exp_pc[2], nxt);
                check_pc(cur_test, exp_pc, new_issue.pc);
                check_issue(cur_test, exp, new_issue);
                exp_pc = (exp.op == op_jalr) ? jalr_target : nxt;
                issued++;
            end
            if (rdy_in && flush_signal) exp_pc = correct_next_pc;
        end
    end

    function automatic word_t fill_word(input word_t a);
        logic [11:0] imm;
        imm = a[11:0] ^ a[23:12] ^ {a[31:24], a[3:0]};
        return {imm, a[16:12] ^ a[31:27], 3'b000, a[6:2] ^ a[11:7], opc_op_imm};
    endfunction

    function automatic word_t rand_word();
        logic [2:0]  f3;
        logic [6:0]  f7;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        logic [11:0] imm;
        word_t       w;
        f3  = $urandom;
        f7  = 7'h00;
        rd  = $urandom;
        rs1 = $urandom;
        rs2 = $urandom;
        imm = $urandom;
        case ($urandom % 6)
            0: begin
                if ((f3 == 3'd0 || f3 == 3'd5) && ($urandom % 2)) f7 = 7'h20;
                w = {f7, rs2, rs1, f3, rd, opc_op};
            end
            1: begin
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    if (f3 == 3'd5 && ($urandom % 2)) f7 = 7'h20;
                    w = {f7, rs2, rs1, f3, rd, opc_op_imm};
                end else begin
                    w = {imm, rs1, f3, rd, opc_op_imm};
                end
            end
            2: w = {imm, rs1, f3, rd, opc_lui};
            3: w = {imm, rs1, f3, rd, opc_auipc};
            4: begin
                if (f3 == 3'd3 || f3 >= 3'd6) f3 = 3'd2;
                w = {imm, rs1, f3, rd, opc_load};
            end
            default: begin
                f3 = f3 % 3;
                w  = {imm[11:5], rs2, rs1, f3, imm[4:0], opc_store};
            end
        endcase
        return w;
    endfunction

    task automatic wait_issues(input int unsigned target);
        int unsigned t;
        t = 0;
        while (!timed_out && issued < target && t < 3000) begin
            @(negedge clk_in);
            t++;
        end
        if (!timed_out && issued < target) begin
            timed_out = 1'b1;
            $display("Timeout in %s: the fetcher stopped issuing instructions", cur_test);
        end
    endtask

    task automatic wait_pending_query();
        int unsigned t;
        t = 0;
        @(posedge clk_in);
        while (!timed_out && !(icache_query_en && !icache_data_en) && t < 200) begin
            @(posedge clk_in);
            t++;
        end
        if (!timed_out && !(icache_query_en && !icache_data_en)) begin
            timed_out = 1'b1;
            $display("Timeout in %s: no cache query became pending", cur_test);
        end
    endtask

    task automatic flush_to(input word_t target);
        @(posedge clk_in);
        flush_signal    <= 1'b1;
        correct_next_pc <= target;
        @(posedge clk_in);
        flush_signal    <= 1'b0;
    endtask

    task automatic run_test(input string name, input word_t start, input int unsigned n);
        int unsigned e0;
        int unsigned i0;
        cur_test = name;
        e0 = errors;
        i0 = issued;
        flush_to(start);
        wait_issues(i0 + n);
        $display("test %s: %0d issues, %0d errors", name, issued - i0, errors - e0);
    endtask

    initial begin : stimulus
        logic [2:0] br_f3 [0:5];
        logic [3:0] off;
        br_f3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        void'($urandom(13));
        errors = 0;
        checks = 0;
        issued = 0;
        stress = 1'b0;
        timed_out = 1'b0;
        exp_pc = reset_pc;
        jalr_target = 32'h0000_0540;
        cur_test = "straight";
        rst_in = 1'b1;
        rdy_in = 1'b1;
        flush_signal = 1'b0;
        correct_next_pc = '0;
        new_instruction_able = 1'b1;
        jalr_result_en = 1'b0;
        jalr_result = '0;
        icache_data_en = 1'b0;
        icache_data = '0;
        predict_result = 1'b0;
        for (int i = 0; i < 1024; i++) mem[i] = fill_word(word_t'(i) << 2);
        for (int i = 0; i < 32; i++) mem[i] = rand_word();
        for (int i = 0; i < 28; i++) begin
            off = ($urandom % 2) ? 4'd4 : 4'd6;   // Forward by 8 or 12 bytes
            if (i % 7 == 6)
                mem[256 + i] = {1'b0, 6'd0, off, 1'b0, 8'd0, 5'd1, opc_jal};
            else
                mem[256 + i] = {7'd0, 5'd3, 5'd2, br_f3[i % 7], off, 1'b0, opc_branch};
        end
        mem[320] = {12'd0, 5'd2, 3'b000, 5'd1, opc_jalr};
        for (int i = 0; i < 32; i++) mem[384 + i] = rand_word();
        mem[448] = 32'hffff_ffff;
        mem[449] = {7'h01, 5'd4, 5'd5, 3'd0, 5'd6, opc_op};
        mem[450] = {7'd0, 5'd1, 5'd2, 3'd2, 4'd4, 1'b0, opc_branch};
        repeat (2) @(posedge clk_in);
        rst_in <= 1'b0;
        wait_issues(32);
        $display("test straight: %0d issues, %0d errors", issued, errors);
        run_test("branches", 32'h0000_0400, 20);
        run_test("jalr", 32'h0000_0500, 4);
        cur_test = "flush";
        wait_pending_query();
        run_test("flush", 32'h0000_0780, 4);
        stress = 1'b1;
        run_test("stalls", 32'h0000_0600, 32);
        stress = 1'b0;
        @(posedge clk_in);
        rdy_in <= 1'b1;
        new_instruction_able <= 1'b1;
        run_test("undefined", 32'h0000_0700, 5);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+verification
rtl/fetch_pkg.sv
rtl/rv32i_decoder.sv
rtl/next_pc_unit.sv
rtl/fetch_control.sv
rtl/instruction_fetcher.sv
verification/fetcher_tb.sv

// ==== Bender.yml ====
package:
  name: instruction_fetcher

sources:
  - files:
      - rtl/fetch_pkg.sv
      - rtl/rv32i_decoder.sv
      - rtl/next_pc_unit.sv
      - rtl/fetch_control.sv
      - rtl/instruction_fetcher.sv
  - target: simulation
    include_dirs:
      - verification
    files:
      - verification/fetcher_tb.sv
